/* logic/cache_pkg.sv */
package cache_pkg;

  // word address and word width of the requester side and of the memory side
  localparam int unsigned ADDR_WIDTH = 8;
  localparam int unsigned DATA_WIDTH = 16;

  // width of the hit and miss counters
  localparam int unsigned COUNT_WIDTH = 16;

  typedef enum logic {
    OP_READ  = 1'b0, // read one word
    OP_WRITE = 1'b1  // write one word through to memory
  } cache_op_e;

  // controller sequence for one request
  typedef enum logic [1:0] {
    IDLE    = 2'd0, // waiting for a request strobe
    RESPOND = 2'd1, // lookup on the held request, answers hits and writes
    FETCH   = 2'd2, // read miss is out on the memory port
    REFILL  = 2'd3  // fetched word goes into the line and back to the requester
  } ctrl_state_e;

  // request from the requester, 25 bits
  typedef struct packed {
    cache_op_e             op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata; // only meaningful for writes
  } cache_req_t;

  // response to the requester, 17 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata; // read data, or the written data on a write
    logic                  hit;   // request was served from the store
  } cache_rsp_t;

  // request towards the word memory, 25 bits
  typedef struct packed {
    logic                  we; // high for write-through, low for a miss fetch
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  // memory only answers fetches so the response is just the word
  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

endpackage

/* logic/cache_srw.sv */
`timescale 1ns/10ps

module cache_srw #(
  // number of lines is 2**IDX_BITS so any index is in range
  parameter int unsigned IDX_BITS = 2
) (
  input  wire                             clk,
  input  wire                             rst_n_i,

  // write port, takes effect on the rising edge
  input  wire                             wr_en_i,
  input  wire  [cache_pkg::ADDR_WIDTH-1:0] wr_addr_i,
  input  wire  [cache_pkg::DATA_WIDTH-1:0] wr_data_i,

  // read port, purely combinational
  input  wire  [cache_pkg::ADDR_WIDTH-1:0] rd_addr_i,
  output logic [cache_pkg::DATA_WIDTH-1:0] rd_data_o,
  output logic                             rd_hit_o   // valid line with matching tag
);

  localparam int unsigned NUM_LINES = 2 ** IDX_BITS;
  localparam int unsigned TAG_WIDTH = cache_pkg::ADDR_WIDTH - IDX_BITS; // upper address bits

  // one line of the store, valid is kept apart since it needs a reset
  typedef struct packed {
    logic [cache_pkg::DATA_WIDTH-1:0] data;
    logic [TAG_WIDTH-1:0]             tag;
  } line_t;

  line_t                line_q [NUM_LINES]; // tag and data storage
  logic [NUM_LINES-1:0] valid_q;            // one bit per line, cleared by reset

  logic [IDX_BITS-1:0]  wr_idx;
  logic [IDX_BITS-1:0]  rd_idx;
  logic [TAG_WIDTH-1:0] rd_tag;
  line_t                wr_line;
  line_t                rd_line;

  // low address bits select the line and the rest is the tag
  assign wr_idx = wr_addr_i[IDX_BITS-1:0];
  assign rd_idx = rd_addr_i[IDX_BITS-1:0];
  assign rd_tag = rd_addr_i[cache_pkg::ADDR_WIDTH-1:IDX_BITS];

  assign wr_line.data = wr_data_i;
  assign wr_line.tag  = wr_addr_i[cache_pkg::ADDR_WIDTH-1:IDX_BITS];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      line_q[wr_idx] <= wr_line; // new tag and data replace the old line
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0; // nothing in the store can hit after reset
    end else if (wr_en_i) begin
      valid_q[wr_idx] <= 1'b1; // any write fills the whole line
    end
  end

  // read side sees the old contents in the cycle of a write to the same line
  assign rd_line   = line_q[rd_idx];
  assign rd_data_o = rd_line.data;
  assign rd_hit_o  = valid_q[rd_idx] && (rd_line.tag == rd_tag);

  // an unknown index would smear X across the valid bits
  a_wr_idx_known : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wr_en_i |-> !$isunknown(wr_idx)
  ) else $error("cache_srw write with unknown line index");

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int unsigned IDX_BITS = 2 // index width of the line store
) (
  input  wire                              clk,
  input  wire                              rst_n_i,

  // requester side
  input  wire                              req_valid_i,
  input  wire  cache_pkg::cache_req_t      req_i,
  output logic                             rsp_valid_o,
  output cache_pkg::cache_rsp_t            rsp_o,

  // memory side
  output logic                             mem_req_valid_o,
  output cache_pkg::mem_req_t              mem_req_o,
  input  wire                              mem_rsp_valid_i,
  input  wire  cache_pkg::mem_rsp_t        mem_rsp_i,

  // line store write port
  output logic                             wr_en_o,
  output logic [cache_pkg::ADDR_WIDTH-1:0] wr_addr_o,
  output logic [cache_pkg::DATA_WIDTH-1:0] wr_data_o,

  // line store read port, answers in the same cycle
  output logic [cache_pkg::ADDR_WIDTH-1:0] rd_addr_o,
  input  wire  [cache_pkg::DATA_WIDTH-1:0] rd_data_i,
  input  wire                              rd_hit_i,

  // one pulse of either kind per request
  output logic                             lookup_hit_o,
  output logic                             lookup_miss_o
);

  cache_pkg::ctrl_state_e           state_q;
  cache_pkg::ctrl_state_e           state_d;
  cache_pkg::cache_req_t            req_q;  // request being served
  logic [cache_pkg::DATA_WIDTH-1:0] fill_q; // word returned by memory on a miss
  logic                             is_write;

  // the store needs at least one index bit and at least one tag bit
  if (IDX_BITS < 1 || IDX_BITS >= cache_pkg::ADDR_WIDTH) begin : g_idx_check
    $error("cache_ctrl IDX_BITS must leave room for both index and tag");
  end

  assign is_write = (req_q.op == cache_pkg::OP_WRITE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= cache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request is only taken in IDLE since there is no back-pressure
  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::IDLE && req_valid_i) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == cache_pkg::FETCH && mem_rsp_valid_i) begin
      fill_q <= mem_rsp_i.rdata; // held for the refill cycle
    end
  end

  // the held address drives both store ports, the line index never changes mid request
  assign rd_addr_o = req_q.addr;
  assign wr_addr_o = req_q.addr;

  // memory payload is fixed by the held request and qualified by the strobe
  assign mem_req_o.we    = is_write;
  assign mem_req_o.addr  = req_q.addr;
  assign mem_req_o.wdata = req_q.wdata;

  always_comb begin
    state_d         = state_q;
    rsp_valid_o     = 1'b0;
    rsp_o           = '0;
    mem_req_valid_o = 1'b0;
    wr_en_o         = 1'b0;
    wr_data_o       = req_q.wdata; // write data unless a refill overrides it
    lookup_hit_o    = 1'b0;
    lookup_miss_o   = 1'b0;

    case (state_q)
      cache_pkg::IDLE: begin
        if (req_valid_i) begin
          state_d = cache_pkg::RESPOND; // lookup happens on the latched address
        end
      end

      cache_pkg::RESPOND: begin
        // counters see every request here, writes included
        lookup_hit_o  = rd_hit_i;
        lookup_miss_o = !rd_hit_i;
        if (is_write) begin
          // write-through: line update, memory write and acknowledge in one cycle
          wr_en_o         = 1'b1;
          mem_req_valid_o = 1'b1;
          rsp_valid_o     = 1'b1;
          rsp_o.rdata     = req_q.wdata;
          rsp_o.hit       = rd_hit_i; // old line matched or not
          state_d         = cache_pkg::IDLE;
        end else if (rd_hit_i) begin
          rsp_valid_o = 1'b1;
          rsp_o.rdata = rd_data_i;
          rsp_o.hit   = 1'b1;
          state_d     = cache_pkg::IDLE;
        end else begin
          mem_req_valid_o = 1'b1; // fetch of the same word address
          state_d         = cache_pkg::FETCH;
        end
      end

      cache_pkg::FETCH: begin
        if (mem_rsp_valid_i) begin
          state_d = cache_pkg::REFILL; // memory latency is open ended
        end
      end

      cache_pkg::REFILL: begin
        wr_en_o     = 1'b1;
        wr_data_o   = fill_q;
        rsp_valid_o = 1'b1;
        rsp_o.rdata = fill_q;
        rsp_o.hit   = 1'b0;
        state_d     = cache_pkg::IDLE;
      end

      default: begin
        state_d = cache_pkg::IDLE;
      end
    endcase
  end

  // requester has to wait for the response before the next strobe
  a_req_only_idle : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    req_valid_i |-> state_q == cache_pkg::IDLE
  ) else $error("cache_ctrl request strobe while busy");

  // memory answers nothing but an outstanding fetch
  a_mem_rsp_only_fetch : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> state_q == cache_pkg::FETCH
  ) else $error("cache_ctrl memory response without a fetch");

  // each request gets a single response strobe
  a_rsp_one_cycle : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o
  ) else $error("cache_ctrl response strobe longer than one cycle");

endmodule

/* logic/cache_stats.sv */
`timescale 1ns/10ps

module cache_stats (
  input  wire                               clk,
  input  wire                               rst_n_i,
  input  wire                               lookup_hit_i,  // one cycle per hit
  input  wire                               lookup_miss_i, // one cycle per miss
  output logic [cache_pkg::COUNT_WIDTH-1:0] hit_count_o,
  output logic [cache_pkg::COUNT_WIDTH-1:0] miss_count_o
);

  // stops at all ones so a long run never reads as a small count
  function automatic logic [cache_pkg::COUNT_WIDTH-1:0] sat_inc(
    input logic [cache_pkg::COUNT_WIDTH-1:0] cnt
  );
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hit_count_o <= '0;
    end else if (lookup_hit_i) begin
      hit_count_o <= sat_inc(hit_count_o);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_count_o <= '0;
    end else if (lookup_miss_i) begin
      miss_count_o <= sat_inc(miss_count_o);
    end
  end

  // a lookup is either one or the other, never both
  a_one_pulse : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(lookup_hit_i && lookup_miss_i)
  ) else $error("cache_stats hit and miss reported together");

endmodule

/* logic/cache_top.sv */
`timescale 1ns/10ps

module cache_top #(
  parameter int unsigned IDX_BITS = 2 // 4 lines by default
) (
  input  wire                               clk,
  input  wire                               rst_n_i,

  // requester
  input  wire                               req_valid_i,
  input  wire  cache_pkg::cache_req_t       req_i,
  output logic                              rsp_valid_o,
  output cache_pkg::cache_rsp_t             rsp_o,

  // word memory
  output logic                              mem_req_valid_o,
  output cache_pkg::mem_req_t               mem_req_o,
  input  wire                               mem_rsp_valid_i,
  input  wire  cache_pkg::mem_rsp_t         mem_rsp_i,

  // performance counters
  output logic [cache_pkg::COUNT_WIDTH-1:0] hit_count_o,
  output logic [cache_pkg::COUNT_WIDTH-1:0] miss_count_o
);

  // controller to store
  logic                             wr_en;
  logic [cache_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [cache_pkg::DATA_WIDTH-1:0] wr_data;
  logic [cache_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [cache_pkg::DATA_WIDTH-1:0] rd_data;
  logic                             rd_hit;

  // controller to counters
  logic                             lookup_hit;
  logic                             lookup_miss;

  cache_ctrl #(
    .IDX_BITS (IDX_BITS)
  ) i_cache_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .wr_en_o         (wr_en),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .rd_addr_o       (rd_addr),
    .rd_data_i       (rd_data),
    .rd_hit_i        (rd_hit),
    .lookup_hit_o    (lookup_hit),
    .lookup_miss_o   (lookup_miss)
  );

  cache_srw #(
    .IDX_BITS (IDX_BITS)
  ) i_cache_srw (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .rd_hit_o  (rd_hit)
  );

  cache_stats i_cache_stats (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .lookup_hit_i  (lookup_hit),
    .lookup_miss_i (lookup_miss),
    .hit_count_o   (hit_count_o),
    .miss_count_o  (miss_count_o)
  );

endmodule

/* test/mem_model.sv */
`timescale 1ns/10ps

module mem_model #(
  parameter int unsigned LATENCY = 3 // cycles from a read strobe to its answer
) (
  input  wire                  clk,
  input  wire                  rst_n_i,
  input  wire                  mem_req_valid_i,
  input  cache_pkg::mem_req_t  mem_req_i,
  output logic                 mem_rsp_valid_o,
  output cache_pkg::mem_rsp_t  mem_rsp_o
);

  // contents are loaded by the testbench at time zero
  logic [cache_pkg::DATA_WIDTH-1:0] words [2 ** cache_pkg::ADDR_WIDTH];
  logic [cache_pkg::ADDR_WIDTH-1:0] fetch_addr_q; // address of the pending fetch
  int unsigned                      wait_q;       // cycles left until the answer

  initial begin
    mem_rsp_valid_o = 1'b0; // quiet before the first reset edge
    mem_rsp_o       = '0;
    wait_q          = 0;
  end

  // works on the falling edge so the answer is stable around the DUT's rising edge
  always @(negedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_rsp_valid_o <= 1'b0;
      mem_rsp_o       <= '0;
      wait_q          <= 0; // a pending fetch is dropped, contents stay
    end else begin
      mem_rsp_valid_o <= 1'b0; // answer strobe lasts one cycle
      if (mem_req_valid_i && mem_req_i.we) begin
        words[mem_req_i.addr] <= mem_req_i.wdata; // writes land at once and get no answer
      end else if (mem_req_valid_i) begin
        fetch_addr_q <= mem_req_i.addr;
        wait_q       <= LATENCY;
      end else if (wait_q != 0) begin
        wait_q <= wait_q - 1;
        if (wait_q == 1) begin
          mem_rsp_valid_o <= 1'b1;
          mem_rsp_o.rdata <= words[fetch_addr_q];
        end
      end
    end
  end

endmodule

/* test/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb;

  localparam int unsigned IDX_BITS     = 2;
  localparam int unsigned TAG_WIDTH    = cache_pkg::ADDR_WIDTH - IDX_BITS;
  localparam int unsigned NUM_LINES    = 2 ** IDX_BITS;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_RANDOM   = 400;
  localparam int unsigned NUM_DIRECTED = 20; // bound on the hand picked requests
  localparam int unsigned MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * 10 + 3 * RESET_CYCLES;

  logic                              clk;
  logic                              rst_n;
  logic                              req_valid;
  cache_pkg::cache_req_t             req;
  logic                              rsp_valid;
  cache_pkg::cache_rsp_t             rsp;
  logic                              mem_req_valid;
  cache_pkg::mem_req_t               mem_req;
  logic                              mem_rsp_valid;
  cache_pkg::mem_rsp_t               mem_rsp;
  logic [cache_pkg::COUNT_WIDTH-1:0] hit_count;
  logic [cache_pkg::COUNT_WIDTH-1:0] miss_count;

  // reference model of memory, line table and counters
  logic [cache_pkg::DATA_WIDTH-1:0] shadow_mem [2 ** cache_pkg::ADDR_WIDTH];
  logic [TAG_WIDTH-1:0]             line_tag [NUM_LINES];
  logic [NUM_LINES-1:0]             line_valid;
  int unsigned                      exp_hits;
  int unsigned                      exp_misses;
  int unsigned                      checks;
  int unsigned                      errors;
  int unsigned                      tests;
  int unsigned                      test_start_errors;
  int unsigned                      cycle_cnt = 0;

  cache_top #(
    .IDX_BITS (IDX_BITS)
  ) i_cache_top (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .rsp_valid_o     (rsp_valid),
    .rsp_o           (rsp),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_i       (mem_rsp),
    .hit_count_o     (hit_count),
    .miss_count_o    (miss_count)
  );

  mem_model #(.LATENCY(3)) i_mem_model (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_i       (mem_req),
    .mem_rsp_valid_o (mem_rsp_valid),
    .mem_rsp_o       (mem_rsp)
  );

  always #50 clk = ~clk; // 100 ns period

  // watchdog, every request finishes well inside ten cycles
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped answering requests", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // every memory word differs in both bytes from its neighbours
  function automatic logic [cache_pkg::DATA_WIDTH-1:0] fill_word(
    input logic [cache_pkg::ADDR_WIDTH-1:0] a
  );
    return {~a, a ^ 8'h96};
  endfunction

  task automatic check_value(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Mismatch at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%-18s %s, %0d errors", name, (errors == test_start_errors) ? "ok" : "failed",
             errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic compare_counters();
    @(negedge clk); // a lookup pulse in the response cycle lands on the following edge
    check_value(hit_count == cache_pkg::COUNT_WIDTH'(exp_hits),
                $sformatf("hit count %0d, expected %0d", hit_count, exp_hits));
    check_value(miss_count == cache_pkg::COUNT_WIDTH'(exp_misses),
                $sformatf("miss count %0d, expected %0d", miss_count, exp_misses));
  endtask

  // one request from strobe to response, checked against the model and then folded into it
  task automatic run_request(input cache_pkg::cache_op_e op,
                             input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                             input logic [cache_pkg::DATA_WIDTH-1:0] wdata,
                             output logic got_hit);
    logic [IDX_BITS-1:0]              idx;
    logic [TAG_WIDTH-1:0]             tag;
    logic                             exp_hit;
    logic [cache_pkg::DATA_WIDTH-1:0] exp_data;
    logic [cache_pkg::ADDR_WIDTH-1:0] seen_addr;
    logic [cache_pkg::DATA_WIDTH-1:0] seen_data;
    cache_pkg::cache_rsp_t            got;
    int unsigned                      cycles;
    int unsigned                      rd_strobes;
    int unsigned                      wr_strobes;
    logic                             done;
    idx      = addr[IDX_BITS-1:0];
    tag      = addr[cache_pkg::ADDR_WIDTH-1:IDX_BITS];
    exp_hit  = line_valid[idx] && (line_tag[idx] == tag); // direct mapped lookup
    exp_data = (op == cache_pkg::OP_WRITE) ? wdata : shadow_mem[addr];
    @(negedge clk);
    req_valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk);
    req_valid  = 1'b0;
    cycles     = 1; // this negedge lies in the cycle after the request edge
    rd_strobes = 0;
    wr_strobes = 0;
    done       = 1'b0;
    while (!done) begin
      if (mem_req_valid) begin
        if (mem_req.we) wr_strobes++;
        else rd_strobes++;
        seen_addr = mem_req.addr;
        seen_data = mem_req.wdata;
      end
      if (rsp_valid) begin
        done = 1'b1;
        got  = rsp;
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    check_value(got.hit == exp_hit,
                $sformatf("%s %h hit %0b, expected %0b", op.name(), addr, got.hit, exp_hit));
    check_value(got.rdata == exp_data,
                $sformatf("%s %h data %h, expected %h", op.name(), addr, got.rdata, exp_data));
    if (op == cache_pkg::OP_WRITE) begin
      check_value(wr_strobes == 1 && rd_strobes == 0 && cycles == 1,
                  $sformatf("write %h gave %0d writes, %0d reads in %0d cycles",
                            addr, wr_strobes, rd_strobes, cycles));
      check_value(seen_addr == addr && seen_data == wdata,
                  $sformatf("write-through %h/%h, expected %h/%h", seen_addr, seen_data,
                            addr, wdata));
      shadow_mem[addr] = wdata;
    end else if (exp_hit) begin
      check_value(rd_strobes == 0 && wr_strobes == 0 && cycles == 1,
                  $sformatf("read hit %h took %0d cycles with %0d mem strobes", addr, cycles,
                            rd_strobes + wr_strobes));
    end else begin
      check_value(rd_strobes == 1 && wr_strobes == 0 && seen_addr == addr,
                  $sformatf("read miss %h gave %0d fetches, last at %h", addr, rd_strobes,
                            seen_addr));
    end
    if (exp_hit) exp_hits++;
    else exp_misses++;
    line_valid[idx] = 1'b1; // writes and read misses both leave the line filled
    line_tag[idx]   = tag;
    got_hit         = got.hit;
  endtask

  initial begin
    logic                             got_hit;
    logic [cache_pkg::ADDR_WIDTH-1:0] addr;
    cache_pkg::cache_op_e             op;
    clk               = 1'b0;
    rst_n             = 1'b0;
    req_valid         = 1'b0;
    req               = '0;
    line_valid        = '0;
    exp_hits          = 0;
    exp_misses        = 0;
    checks            = 0;
    errors            = 0;
    tests             = 0;
    test_start_errors = 0;
    void'($urandom(32'h7c79));
    for (int a = 0; a < 2 ** cache_pkg::ADDR_WIDTH; a++) begin
      shadow_mem[a]         = fill_word(cache_pkg::ADDR_WIDTH'(a));
      i_mem_model.words[a]  = shadow_mem[a]; // memory starts equal to the shadow
    end
    apply_reset();

    run_request(cache_pkg::OP_READ, 8'h05, '0, got_hit);
    check_value(!got_hit, "first read after reset did not miss");
    finish_test("first_read_miss");

    run_request(cache_pkg::OP_READ, 8'h05, '0, got_hit);
    check_value(got_hit, "repeated read of 05 did not hit");
    run_request(cache_pkg::OP_READ, 8'h05, '0, got_hit);
    finish_test("repeat_read_hit");

    run_request(cache_pkg::OP_WRITE, 8'h0a, 16'hbeef, got_hit);
    run_request(cache_pkg::OP_READ, 8'h0a, '0, got_hit);
    check_value(got_hit, "read after write of 0a did not hit");
    finish_test("write_through");

    // 21 and 25 share index 1 and keep throwing each other out
    for (int n = 0; n < 6; n++) begin
      run_request(cache_pkg::OP_READ, (n % 2 == 0) ? 8'h21 : 8'h25, '0, got_hit);
      check_value(!got_hit, $sformatf("conflicting read %0d did not miss", n));
    end
    finish_test("conflict_evict");

    // sixteen addresses over four lines keep conflicts and refills frequent
    for (int n = 0; n < NUM_RANDOM; n++) begin
      addr = cache_pkg::ADDR_WIDTH'($urandom_range(15, 0));
      op   = ($urandom_range(2, 0) == 0) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
      run_request(op, addr, cache_pkg::DATA_WIDTH'($urandom), got_hit);
    end
    compare_counters();
    finish_test("random_traffic");

    // line 2 holds 0a going into the reset, so a valid bit that survives would hit
    run_request(cache_pkg::OP_READ, 8'h0a, '0, got_hit);
    apply_reset();
    line_valid = '0;
    exp_hits   = 0;
    exp_misses = 0;
    compare_counters();
    run_request(cache_pkg::OP_READ, 8'h0a, '0, got_hit);
    check_value(!got_hit, "read after mid-run reset did not miss");
    compare_counters();
    finish_test("mid_run_reset");

    $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
logic/cache_pkg.sv
logic/cache_srw.sv
logic/cache_ctrl.sv
logic/cache_stats.sv
logic/cache_top.sv
test/mem_model.sv
test/cache_tb.sv

/* Bender.yml */
package:
  name: cache

# direct-mapped write-through cache with a testbench
sources:
  # package first, the modules refer to its types
  - logic/cache_pkg.sv
  - logic/cache_srw.sv
  - logic/cache_ctrl.sv
  - logic/cache_stats.sv
  - logic/cache_top.sv

  # simulation only, top module is cache_tb
  - target: test
    files:
      - test/mem_model.sv
      - test/cache_tb.sv
